// ==== hw/trace_pkg.sv ====
// shared widths, record types and FSM states for the trace sniffer, referenced by scoped names
`default_nettype none

package trace_pkg;

   localparam int NIBBLE_BITS      = 4;
   localparam int WINDOW_NIBBLES   = 8;
   localparam int WINDOW_BITS      = NIBBLE_BITS * WINDOW_NIBBLES; // 32
   localparam int NUM_RULES        = 4;
   localparam int RULE_IDX_BITS    = 2;
   localparam int TIMESTAMP_BITS   = 16;
   localparam int COUNT_BITS       = 8;
   localparam int FIFO_DEPTH       = 16;
   localparam int FIFO_ADDR_BITS   = 4;
   localparam int CAPTURE_LEN_BITS = 8;
   localparam int DELAY_BITS       = 8;
   localparam int WIDTH_BITS       = 8;

   typedef logic [NIBBLE_BITS-1:0]    nibble_t;
   typedef logic [WINDOW_BITS-1:0]    window_t;    // newest nibble in [3:0]
   typedef logic [RULE_IDX_BITS-1:0]  rule_idx_t;
   typedef logic [TIMESTAMP_BITS-1:0] timestamp_t;
   typedef logic [COUNT_BITS-1:0]     count_t;

   // one captured match, 18 bits
   typedef struct packed {
      rule_idx_t  rule;
      timestamp_t timestamp;
   } event_rec_t;

   typedef enum logic [1:0] {
      CAP_IDLE,
      CAP_RUN,
      CAP_DONE
   } capture_state_e;

   typedef enum logic [1:0] {
      TRIG_IDLE,
      TRIG_DELAY,
      TRIG_PULSE
   } trig_state_e;

endpackage

`default_nettype wire

// ==== hw/event_if.sv ====
// record link from the capture FSM into the event FIFO, with back-pressure and clear
`timescale 1ns/1ps
`default_nettype none

interface event_if;

   logic                  wr;    // one-cycle write strobe
   trace_pkg::event_rec_t rec;
   logic                  full;  // level from FIFO
   logic                  clear; // empties FIFO on arm

   modport producer (output wr, output rec, output clear, input full);
   modport consumer (input wr, input rec, input clear, output full);

endinterface

`default_nettype wire

// ==== hw/trace_deserializer.sv ====
// shifts the 4-bit trace port into the 8-nibble match window used by the pattern matcher
`timescale 1ns/1ps
`default_nettype none

module trace_deserializer (
   input  wire                      trace_clk,
   input  wire                      reset,
   input  wire trace_pkg::nibble_t  trace_data,
   output trace_pkg::window_t       window,
   output logic                     window_valid
);

   logic [$clog2(trace_pkg::WINDOW_NIBBLES)-1:0] nib_cnt;

   // newest nibble enters at the bottom
   always_ff @(posedge trace_clk) begin
      window <= {window[trace_pkg::WINDOW_BITS-trace_pkg::NIBBLE_BITS-1:0], trace_data};
   end

   // window is valid once it has been filled completely
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         nib_cnt      <= '0;
         window_valid <= 1'b0;
      end else if (!window_valid) begin
         nib_cnt <= nib_cnt + 1'b1;
         if (nib_cnt == '1) begin
            window_valid <= 1'b1; // eighth nibble lands this edge
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/pattern_matcher.sv ====
// four masked pattern rules checked against the window every cycle, with hit counters
`timescale 1ns/1ps
`default_nettype none

module pattern_matcher (
   input  wire                        trace_clk,
   input  wire                        reset,
   input  wire trace_pkg::window_t    window,
   input  wire                        window_valid,
   input  wire                        rule_write,
   input  wire trace_pkg::rule_idx_t  rule_sel,
   input  wire trace_pkg::window_t    rule_pattern,
   input  wire trace_pkg::window_t    rule_mask,
   input  wire                        rule_enable,
   input  wire                        rule_trig_enable,
   input  wire trace_pkg::rule_idx_t  count_sel,
   output trace_pkg::count_t          rule_count,
   output logic                       hit,
   output trace_pkg::rule_idx_t       hit_rule,
   output logic                       trig_hit
);

   trace_pkg::window_t                 pattern [trace_pkg::NUM_RULES];
   trace_pkg::window_t                 mask    [trace_pkg::NUM_RULES];
   logic [trace_pkg::NUM_RULES-1:0]    enable;
   logic [trace_pkg::NUM_RULES-1:0]    trig_enable;
   logic [trace_pkg::NUM_RULES-1:0]    match;
   trace_pkg::rule_idx_t               first_rule;
   trace_pkg::count_t                  counts  [trace_pkg::NUM_RULES];

   always_ff @(posedge trace_clk) begin
      if (rule_write) begin
         pattern[rule_sel] <= rule_pattern;
         mask[rule_sel]    <= rule_mask;
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         enable      <= '0;
         trig_enable <= '0;
      end else if (rule_write) begin
         enable[rule_sel]      <= rule_enable;
         trig_enable[rule_sel] <= rule_trig_enable;
      end
   end

   // only bits set in the mask take part in the compare
   always_comb begin
      for (int i = 0; i < trace_pkg::NUM_RULES; i++) begin
         match[i] = enable[i] & window_valid & (((window ^ pattern[i]) & mask[i]) == '0);
      end
   end

   // lowest-numbered rule wins
   always_comb begin
      first_rule = '0;
      for (int i = trace_pkg::NUM_RULES - 1; i >= 0; i--) begin
         if (match[i]) begin
            first_rule = trace_pkg::rule_idx_t'(i);
         end
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         hit      <= 1'b0;
         hit_rule <= '0;
         trig_hit <= 1'b0;
      end else begin
         hit      <= |match;
         hit_rule <= first_rule;
         trig_hit <= |(match & trig_enable);
      end
   end

   // counts run whether armed or not
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         for (int i = 0; i < trace_pkg::NUM_RULES; i++) begin
            counts[i] <= '0;
         end
      end else begin
         for (int i = 0; i < trace_pkg::NUM_RULES; i++) begin
            if (match[i] && counts[i] != '1) begin
               counts[i] <= counts[i] + 1'b1; // stops at 255
            end
         end
      end
   end

   assign rule_count = counts[count_sel];

endmodule

`default_nettype wire

// ==== hw/event_capture.sv ====
// armed capture FSM that turns matcher hits into timestamped records for the event FIFO
`timescale 1ns/1ps
`default_nettype none

module event_capture (
   input  wire                                         trace_clk,
   input  wire                                         reset,
   input  wire                                         arm,
   input  wire [trace_pkg::CAPTURE_LEN_BITS-1:0]       capture_len,
   input  wire                                         hit,
   input  wire trace_pkg::rule_idx_t                   hit_rule,
   event_if.producer                                   ev,
   output logic                                        capturing,
   output logic                                        overflow
);

   trace_pkg::capture_state_e                 state;
   trace_pkg::timestamp_t                     ts;
   logic                                      pend;     // record waiting to be written
   trace_pkg::event_rec_t                     pend_rec;
   logic [trace_pkg::CAPTURE_LEN_BITS-1:0]    rec_cnt;
   logic                                      run;

   assign run       = (state == trace_pkg::CAP_RUN);
   assign capturing = run;

   // full is sampled in the write cycle itself, so a strobe never meets a full FIFO
   assign ev.wr  = pend & run & ~ev.full;
   assign ev.rec = pend_rec;

   always_ff @(posedge trace_clk) begin
      if (hit) begin
         pend_rec <= '{rule: hit_rule, timestamp: ts};
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         state    <= trace_pkg::CAP_IDLE;
         ts       <= '0;
         pend     <= 1'b0;
         rec_cnt  <= '0;
         overflow <= 1'b0;
         ev.clear <= 1'b0;
      end else begin
         ev.clear <= arm;
         if (ts != '1) begin
            ts <= ts + 1'b1; // saturating
         end
         if (arm) begin
            state    <= trace_pkg::CAP_RUN;
            ts       <= '0;
            pend     <= 1'b0;
            rec_cnt  <= '0;
            overflow <= 1'b0;
         end else begin
            pend <= hit & run;
            if (pend && run) begin
               if (ev.full) begin
                  overflow <= 1'b1; // record lost but still counted
               end
               rec_cnt <= rec_cnt + 1'b1;
               if (rec_cnt + 1'b1 == capture_len) begin
                  state <= trace_pkg::CAP_DONE;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/event_fifo.sv ====
// 16-entry show-ahead FIFO holding event records until the host reads them out
`timescale 1ns/1ps
`default_nettype none

module event_fifo (
   input  wire                      trace_clk,
   input  wire                      reset,
   event_if.consumer                ev,
   input  wire                      fifo_read,
   output trace_pkg::event_rec_t    fifo_data,
   output logic                     fifo_empty
);

   trace_pkg::event_rec_t                   mem [trace_pkg::FIFO_DEPTH];
   logic [trace_pkg::FIFO_ADDR_BITS-1:0]    wr_ptr;
   logic [trace_pkg::FIFO_ADDR_BITS-1:0]    rd_ptr;
   logic [trace_pkg::FIFO_ADDR_BITS:0]      fill;
   logic                                    do_wr;
   logic                                    do_rd;

   assign ev.full    = fill[trace_pkg::FIFO_ADDR_BITS]; // depth is a power of two
   assign fifo_empty = (fill == '0);
   assign fifo_data  = mem[rd_ptr];                     // oldest entry on show

   assign do_wr = ev.wr & ~ev.full;
   assign do_rd = fifo_read & ~fifo_empty;

   always_ff @(posedge trace_clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= ev.rec;
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset || ev.clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill; // both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/trigger_pulse.sv ====
// single trigger pulse after a programmable delay, for a fixed number of trace clocks
`timescale 1ns/1ps
`default_nettype none

module trigger_pulse (
   input  wire                                   trace_clk,
   input  wire                                   reset,
   input  wire                                   trig_hit,
   input  wire [trace_pkg::DELAY_BITS-1:0]       trigger_delay,
   input  wire [trace_pkg::WIDTH_BITS-1:0]       trigger_width,
   output logic                                  trace_trig_out
);

   trace_pkg::trig_state_e              state;
   logic [trace_pkg::DELAY_BITS-1:0]    cnt; // delay first, then width

   assign trace_trig_out = (state == trace_pkg::TRIG_PULSE);

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         state <= trace_pkg::TRIG_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            trace_pkg::TRIG_IDLE: begin
               // new hits are only taken here
               if (trig_hit && trigger_width != '0) begin
                  if (trigger_delay == '0) begin
                     state <= trace_pkg::TRIG_PULSE;
                     cnt   <= trigger_width - 1'b1;
                  end else begin
                     state <= trace_pkg::TRIG_DELAY;
                     cnt   <= trigger_delay - 1'b1;
                  end
               end
            end
            trace_pkg::TRIG_DELAY: begin
               if (cnt != '0) begin
                  cnt <= cnt - 1'b1;
               end else if (trigger_width == '0) begin
                  state <= trace_pkg::TRIG_IDLE; // width cleared meanwhile
               end else begin
                  state <= trace_pkg::TRIG_PULSE;
                  cnt   <= trigger_width - 1'b1;
               end
            end
            trace_pkg::TRIG_PULSE: begin
               if (cnt != '0) begin
                  cnt <= cnt - 1'b1;
               end else begin
                  state <= trace_pkg::TRIG_IDLE;
               end
            end
            default: state <= trace_pkg::TRIG_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/trace_top.sv ====
// trace sniffer top level joining deserializer, matcher, capture, FIFO and trigger stages
`timescale 1ns/1ps
`default_nettype none

module trace_top (
   input  wire                                   trace_clk,
   input  wire                                   reset,
   input  wire trace_pkg::nibble_t               trace_data,
   input  wire                                   rule_write,
   input  wire trace_pkg::rule_idx_t             rule_sel,
   input  wire trace_pkg::window_t               rule_pattern,
   input  wire trace_pkg::window_t               rule_mask,
   input  wire                                   rule_enable,
   input  wire                                   rule_trig_enable,
   input  wire trace_pkg::rule_idx_t             count_sel,
   output wire trace_pkg::count_t                rule_count,
   input  wire                                   arm,
   input  wire [trace_pkg::CAPTURE_LEN_BITS-1:0] capture_len,
   input  wire [trace_pkg::DELAY_BITS-1:0]       trigger_delay,
   input  wire [trace_pkg::WIDTH_BITS-1:0]       trigger_width,
   input  wire                                   fifo_read,
   output wire trace_pkg::event_rec_t            fifo_data,
   output wire                                   fifo_empty,
   output wire                                   overflow,
   output wire                                   capturing,
   output wire                                   trace_trig_out
);

   trace_pkg::window_t      window;
   logic                    window_valid;
   logic                    hit;
   trace_pkg::rule_idx_t    hit_rule;
   logic                    trig_hit;

   event_if ev ();

   trace_deserializer u_deserializer (
      .trace_clk        (trace_clk),
      .reset            (reset),
      .trace_data       (trace_data),
      .window           (window),
      .window_valid     (window_valid)
   );

   pattern_matcher u_matcher (
      .trace_clk        (trace_clk),
      .reset            (reset),
      .window           (window),
      .window_valid     (window_valid),
      .rule_write       (rule_write),
      .rule_sel         (rule_sel),
      .rule_pattern     (rule_pattern),
      .rule_mask        (rule_mask),
      .rule_enable      (rule_enable),
      .rule_trig_enable (rule_trig_enable),
      .count_sel        (count_sel),
      .rule_count       (rule_count),
      .hit              (hit),
      .hit_rule         (hit_rule),
      .trig_hit         (trig_hit)
   );

   event_capture u_capture (
      .trace_clk        (trace_clk),
      .reset            (reset),
      .arm              (arm),
      .capture_len      (capture_len),
      .hit              (hit),
      .hit_rule         (hit_rule),
      .ev               (ev.producer),
      .capturing        (capturing),
      .overflow         (overflow)
   );

   event_fifo u_fifo (
      .trace_clk        (trace_clk),
      .reset            (reset),
      .ev               (ev.consumer),
      .fifo_read        (fifo_read),
      .fifo_data        (fifo_data),
      .fifo_empty       (fifo_empty)
   );

   trigger_pulse u_trigger (
      .trace_clk        (trace_clk),
      .reset            (reset),
      .trig_hit         (trig_hit),
      .trigger_delay    (trigger_delay),
      .trigger_width    (trigger_width),
      .trace_trig_out   (trace_trig_out)
   );

endmodule

`default_nettype wire

// ==== verification/trace_chk.sv ====
// assertion checker bound into the trace sniffer top level for reset, FIFO and pulse rules
`timescale 1ns/1ps
`default_nettype none

module trace_chk (
   input wire       trace_clk,
   input wire       reset,
   input wire       capturing,
   input wire       trace_trig_out,
   input wire [7:0] trigger_width,
   input wire       wr,
   input wire       clear,
   input wire       fifo_read
);

   logic [8:0] high_cnt; // cycles the pulse has already been high
   logic [4:0] occ;      // records held, counted from the link strobes
   logic       pop;

   assign pop = fifo_read && occ != '0; // read of an empty FIFO does nothing

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         high_cnt <= '0;
      end else if (trace_trig_out) begin
         high_cnt <= high_cnt + 1'b1;
      end else begin
         high_cnt <= '0;
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset || clear) begin
         occ <= '0;
      end else if (wr && !pop) begin
         occ <= occ + 1'b1;
      end else if (!wr && pop) begin
         occ <= occ - 1'b1;
      end
   end

   quiet_after_reset: assert property (@(posedge trace_clk)
      reset |=> !capturing && !trace_trig_out)
      else $error("capturing or trigger high after reset");

   no_write_when_full: assert property (@(posedge trace_clk) disable iff (reset)
      wr |-> occ < trace_pkg::FIFO_DEPTH)
      else $error("record write while FIFO full");

   pulse_width_limit: assert property (@(posedge trace_clk) disable iff (reset)
      trace_trig_out |-> high_cnt < {1'b0, trigger_width})
      else $error("trigger pulse longer than trigger_width");

endmodule

bind trace_top trace_chk u_chk (
   .trace_clk      (trace_clk),
   .reset          (reset),
   .capturing      (capturing),
   .trace_trig_out (trace_trig_out),
   .trigger_width  (trigger_width),
   .wr             (ev.wr),
   .clear          (ev.clear),
   .fifo_read      (fifo_read)
);

`default_nettype wire

// ==== verification/trace_tb.sv ====
// testbench for the trace sniffer top level, with a cycle model of rules, capture and trigger
`timescale 1ns/1ps
`default_nettype none

module trace_tb;

   localparam int CYCLE_LIMIT = 2 * (700 + 260 + 150 + 330 + 110); // sum of test lengths, doubled

   logic                   trace_clk;
   logic                   reset;
   trace_pkg::nibble_t     trace_data;
   logic                   rule_write;
   trace_pkg::rule_idx_t   rule_sel;
   trace_pkg::window_t     rule_pattern;
   trace_pkg::window_t     rule_mask;
   logic                   rule_enable;
   logic                   rule_trig_enable;
   trace_pkg::rule_idx_t   count_sel;
   wire trace_pkg::count_t rule_count;
   logic                   arm;
   logic [7:0]             capture_len;
   logic [7:0]             trigger_delay;
   logic [7:0]             trigger_width;
   logic                   fifo_read;
   wire trace_pkg::event_rec_t fifo_data;
   wire                    fifo_empty;
   wire                    overflow;
   wire                    capturing;
   wire                    trace_trig_out;

   // reference model state, advanced on every rising edge
   trace_pkg::window_t     m_window;
   trace_pkg::window_t     m_pat [4];
   trace_pkg::window_t     m_mask [4];
   logic [3:0]             m_en;
   logic [3:0]             m_ten;
   int                     m_nibs;
   int                     m_count [4];
   logic                   m_armed;
   int                     exp_rule [$];
   int                     exp_edge [$];
   int                     trig_start;
   int                     trig_end;
   int                     trig_busy;
   logic                   exp_trig;
   int                     cycle;
   int                     errors;
   int                     mark;
   int                     trig_high;
   logic [31:0]            seed;

   trace_top i_trace_top (.*);

   initial begin
      trace_clk = 1'b0;
      forever #50 trace_clk = ~trace_clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // per-rule match on a window, from the masked compare rule
   function automatic logic [3:0] ref_match(input trace_pkg::window_t w, input logic valid);
      logic [3:0] m;
      for (int i = 0; i < 4; i++) begin
         m[i] = m_en[i] && valid && (((w ^ m_pat[i]) & m_mask[i]) == 32'h0);
      end
      return m;
   endfunction

   always @(posedge trace_clk) begin : model
      logic [3:0] m;
      int         first;
      cycle = cycle + 1;
      if (cycle > CYCLE_LIMIT) begin
         $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
         $display("Finished with errors");
         $finish;
      end else if (reset) begin
         m_en     = '0;
         m_ten    = '0;
         m_nibs   = 0;
         exp_trig = 1'b0;
         for (int i = 0; i < 4; i++) m_count[i] = 0;
      end else begin
         if (rule_write) begin
            m_pat[rule_sel]  = rule_pattern;
            m_mask[rule_sel] = rule_mask;
            m_en[rule_sel]   = rule_enable;
            m_ten[rule_sel]  = rule_trig_enable;
         end
         m_window = {m_window[27:0], trace_data}; // newest nibble low
         if (m_nibs < 8) m_nibs = m_nibs + 1;
         if (arm) begin
            m_armed = 1'b1;
            exp_rule.delete();
            exp_edge.delete();
         end
         m = ref_match(m_window, m_nibs >= 8);
         first = 0;
         for (int i = 3; i >= 0; i--) begin
            if (m[i]) first = i;
            if (m[i] && m_count[i] < 255) m_count[i] = m_count[i] + 1;
         end
         if (m_armed && m != 4'h0) begin
            exp_rule.push_back(first);
            exp_edge.push_back(cycle);
         end
         // trigger accepted only when idle and width nonzero
         if ((m & m_ten) != 4'h0 && cycle >= trig_busy && trigger_width != 8'h0) begin
            trig_start = cycle + int'(trigger_delay) + 2;
            trig_end   = trig_start + int'(trigger_width);
            trig_busy  = cycle + int'(trigger_delay) + int'(trigger_width) + 1;
         end
         exp_trig = (cycle >= trig_start) && (cycle < trig_end);
      end
   end

   task automatic check(input string what, input int got, input int exp);
      if (got !== exp) begin
         errors = errors + 1;
         $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   // trigger output compared every cycle on the falling edge
   always @(negedge trace_clk) begin
      if (!reset) begin
         check("trace_trig_out", int'(trace_trig_out), int'(exp_trig));
         if (trace_trig_out) trig_high = trig_high + 1;
      end
   end

   task automatic finish_test(input string name);
      $display("test %s done: %0d errors", name, errors - mark);
      mark = errors;
   endtask

   task automatic send(input trace_pkg::nibble_t n);
      @(negedge trace_clk);
      trace_data = n;
   endtask

   task automatic send_random(input int n);
      repeat (n) begin
         seed = lcg_next(seed);
         send(seed[19:16]);
      end
   endtask

   task automatic send_zeros(input int n);
      repeat (n) send(4'h0);
   endtask

   task automatic insert_word(input trace_pkg::window_t w);
      for (int i = 7; i >= 0; i--) send(w[i*4 +: 4]); // oldest nibble first
   endtask

   task automatic write_rule(input int idx, input trace_pkg::window_t pat,
                             input trace_pkg::window_t msk, input logic en, input logic ten);
      @(negedge trace_clk);
      rule_write       = 1'b1;
      rule_sel         = 2'(idx);
      rule_pattern     = pat;
      rule_mask        = msk;
      rule_enable      = en;
      rule_trig_enable = ten;
      @(negedge trace_clk);
      rule_write = 1'b0;
   endtask

   task automatic arm_capture(input int len);
      @(negedge trace_clk);
      arm         = 1'b1;
      capture_len = 8'(len);
      @(negedge trace_clk);
      arm = 1'b0;
   endtask

   task automatic wait_capture_done();
      int n;
      n = 0;
      while (capturing && n < 100) begin
         @(negedge trace_clk);
         n = n + 1;
      end
      if (capturing) begin
         errors = errors + 1;
         $display("capture did not stop within 100 cycles at %0t", $time);
      end
   endtask

   // pops every record and compares rule and timestamp step with the model
   task automatic drain(input int n_exp);
      int                    got;
      trace_pkg::timestamp_t prev_ts;
      got     = 0;
      prev_ts = '0;
      @(negedge trace_clk);
      while (!fifo_empty && got < 32) begin
         if (got < exp_rule.size()) begin
            check("record rule", int'(fifo_data.rule), exp_rule[got]);
            if (got > 0) begin
               check("timestamp step", int'(fifo_data.timestamp) - int'(prev_ts),
                     exp_edge[got] - exp_edge[got-1]);
            end
         end
         prev_ts   = fifo_data.timestamp;
         fifo_read = 1'b1;
         got       = got + 1;
         @(negedge trace_clk);
         fifo_read = 1'b0;
         @(negedge trace_clk);
      end
      check("records drained", got, n_exp);
   endtask

   initial begin
      reset = 1'b1;
      trace_data = '0;
      rule_write = 1'b0;
      rule_sel = '0;
      rule_pattern = '0;
      rule_mask = '0;
      rule_enable = 1'b0;
      rule_trig_enable = 1'b0;
      count_sel = '0;
      arm = 1'b0;
      capture_len = '0;
      trigger_delay = '0;
      trigger_width = '0;
      fifo_read = 1'b0;
      seed = 32'hafc7;
      m_window = '0;
      m_armed = 1'b0;
      trig_start = 0;
      trig_end = 0;
      trig_busy = 0;
      exp_trig = 1'b0;
      cycle = 0;
      errors = 0;
      mark = 0;
      trig_high = 0;
      repeat (4) @(negedge trace_clk);
      reset = 1'b0;

      // no pattern is zero under its mask, so idle zeros never match
      write_rule(0, 32'hcafe_0000, 32'hffff_0000, 1'b1, 1'b0);
      write_rule(1, 32'h0000_beef, 32'h0000_ffff, 1'b1, 1'b0);
      write_rule(2, 32'h1234_5678, 32'hffff_ffff, 1'b1, 1'b0);
      write_rule(3, 32'ha0a0_a0a0, 32'hf0f0_f0f0, 1'b1, 1'b0);

      send_random(200);
      insert_word(32'h1234_5678);
      send_random(20);
      insert_word(32'hcafe_1234);
      send_random(20);
      insert_word(32'hcafe_beef); // rules 0 and 1 both hit
      send_random(20);
      insert_word(32'h0000_beef);
      send_random(20);
      insert_word(32'h1234_5678);
      repeat (300) send(4'ha);    // drives rule 3 into saturation
      send_zeros(12);
      for (int i = 0; i < 4; i++) begin
         @(negedge trace_clk);
         count_sel = 2'(i);
         @(negedge trace_clk);
         check("rule count", int'(rule_count), m_count[i]);
      end
      finish_test("rule counts");

      arm_capture(255);
      send_random(30);
      for (int i = 0; i < 8; i++) begin
         case (i % 3)
            0:       insert_word(32'h1234_5678);
            1:       insert_word(32'hcafe_beef);
            default: insert_word(32'hcafe_0101);
         endcase
         send_random(10);
      end
      send_zeros(12);
      drain(exp_rule.size() > 16 ? 16 : exp_rule.size());
      check("overflow", int'(overflow), 0);
      finish_test("event records");

      arm_capture(5);
      repeat (7) begin
         insert_word(32'h1234_5678);
         send_zeros(4);
      end
      wait_capture_done();
      check("capturing", int'(capturing), 0);
      check("overflow", int'(overflow), 0);
      drain(5);
      finish_test("capture length");

      arm_capture(20);
      for (int i = 0; i < 20; i++) begin
         insert_word(i % 2 == 0 ? 32'h1234_5678 : 32'h0000_beef);
         send_zeros(4);
      end
      send_zeros(12);
      wait_capture_done();
      check("overflow", int'(overflow), 1);
      drain(16);
      finish_test("overflow");

      write_rule(3, 32'ha0a0_a0a0, 32'hf0f0_f0f0, 1'b1, 1'b1);
      @(negedge trace_clk);
      trigger_delay = 8'd3;
      trigger_width = 8'd12;
      send_zeros(10);
      trig_high = 0;
      insert_word(32'ha0a0_a0a0);
      insert_word(32'ha0a0_a0a0); // matches again while the pulse runs
      send_zeros(30);
      check("pulse cycles", trig_high, 12);
      @(negedge trace_clk);
      trigger_width = 8'd0;
      insert_word(32'ha0a0_a0a0);
      send_zeros(30);
      check("pulse cycles with width 0", trig_high, 12);
      finish_test("trigger pulse");

      $display("tests done: %0d errors in %0d cycles", errors, cycle);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
hw/trace_pkg.sv
hw/event_if.sv
hw/trace_deserializer.sv
hw/pattern_matcher.sv
hw/event_capture.sv
hw/event_fifo.sv
hw/trigger_pulse.sv
hw/trace_top.sv
verification/trace_chk.sv
verification/trace_tb.sv

// ==== Makefile ====
SIM = obj_dir/trace_sim

.PHONY: all run lint clean

all: run

$(SIM): src.f hw/*.sv verification/*.sv
	verilator --binary --timing --assert -f src.f --top-module trace_tb -o trace_sim

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "Finished with no errors"

lint:
	verilator --lint-only --timing --assert -f src.f --top-module trace_tb

clean:
	rm -rf obj_dir
